// ==== include/msx_cart_config.svh ====
`ifndef MSX_CART_CONFIG_SVH
`define MSX_CART_CONFIG_SVH

// Number of cartridge contexts with their own mapper registers
`define MSX_CART_CONTEXTS 2

// Battery SRAM depth in bytes
`define MSX_CART_SRAM_WORDS 8192

// Request edge to rd_data visible, in cycles
// Decode, mapper and memory port each add one register stage
`define MSX_CART_RD_LATENCY 3

`endif

// ==== msx_cart.f ====
+incdir+include
src/msx_cart_pkg.sv
src/cart_bus_decode.sv
src/mapper_ascii8.sv
src/cart_mem_port.sv
src/msx_cart_top.sv
testbench/tb_msx_cart.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module tb_msx_cart -f msx_cart.f -o tb_msx_cart \
    && ./obj_dir/tb_msx_cart | tee sim.log \
    || { echo "Build or run of the simulation failed"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

// ==== src/cart_bus_decode.sv ====
module cart_bus_decode (
    input  logic                       cpu_bus,
    input  logic                       arst_n,
    input  logic                       req,
    input  logic                       rd,
    input  logic                       wr,
    input  logic                       mreq,
    input  msx_cart_pkg::cpu_addr_t    addr,
    input  msx_cart_pkg::cpu_data_t    wr_data,
    input  msx_cart_pkg::ctx_id_t      ctx,
    input  msx_cart_pkg::mapper_type_t typ,
    input  msx_cart_pkg::rom_size_t    rom_size,
    input  msx_cart_pkg::sram_size_t   sram_size,
    output logic                       dec_valid,
    output logic                       dec_rd,
    output logic                       dec_wr,
    output msx_cart_pkg::cpu_addr_t    dec_addr,
    output msx_cart_pkg::cpu_data_t    dec_data,
    output msx_cart_pkg::ctx_id_t      dec_ctx,
    output logic                       dec_cs,
    output logic                       dec_koei,
    output logic                       dec_wizardy,
    output msx_cart_pkg::rom_size_t    dec_rom_size,
    output msx_cart_pkg::sram_size_t   dec_sram_size
);
    import msx_cart_pkg::*;

    logic mapped;
    logic mapper_en;

    // Window 4000h..BFFFh, top two address bits differ
    assign mapped    = ^addr[15:14];
    assign mapper_en = (typ == MAPPER_ASCII8) | (typ == MAPPER_KOEI) |
                       (typ == MAPPER_WIZARDY);

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec_rd    <= 1'b0;
            dec_wr    <= 1'b0;
            dec_cs    <= 1'b0;
        end else begin
            dec_valid <= req;
            dec_rd    <= req & rd;
            dec_wr    <= req & wr;
            dec_cs    <= req & mreq & mapped & mapper_en;
        end
    end

    // Request payload and static configuration
    always_ff @(posedge cpu_bus) begin
        dec_addr      <= addr;
        dec_data      <= wr_data;
        dec_ctx       <= ctx;
        dec_koei      <= (typ == MAPPER_KOEI);
        dec_wizardy   <= (typ == MAPPER_WIZARDY);
        dec_rom_size  <= rom_size;
        dec_sram_size <= sram_size;
    end

    a_rd_wr_exclusive: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        req |-> !(rd && wr));

endmodule

// ==== src/cart_mem_port.sv ====
`include "msx_cart_config.svh"

module cart_mem_port (
    input  logic                    cpu_bus,
    input  logic                    arst_n,
    input  logic                    map_valid,
    input  logic                    map_rom_cs,
    input  logic                    map_sram_cs,
    input  logic                    map_sram_wr,
    input  msx_cart_pkg::mem_addr_t map_addr,
    input  msx_cart_pkg::cpu_data_t map_data,
    output logic                    rom_rd,
    output msx_cart_pkg::mem_addr_t rom_addr,
    output logic                    sram_cs,
    output msx_cart_pkg::cpu_data_t rd_data,
    output logic                    rd_valid
);
    import msx_cart_pkg::*;

    localparam int SRAM_AW = $clog2(`MSX_CART_SRAM_WORDS);

    // Battery-backed cartridge SRAM
    cpu_data_t sram_q [`MSX_CART_SRAM_WORDS];

    logic               sram_wr;
    logic               sram_rd;
    logic [SRAM_AW-1:0] sram_idx;

    assign sram_wr  = map_valid & map_sram_cs & map_sram_wr;
    assign sram_rd  = map_valid & map_sram_cs & ~map_sram_wr;
    // SRAM wraps on its own depth
    assign sram_idx = map_addr[SRAM_AW-1:0];

    always_ff @(posedge cpu_bus) begin
        if (sram_wr) begin
            sram_q[sram_idx] <= map_data;
        end
        if (sram_rd) begin
            rd_data <= sram_q[sram_idx];
        end
    end

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            rom_rd   <= 1'b0;
            rom_addr <= '1;
            sram_cs  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rom_rd   <= map_valid & map_rom_cs;
            sram_cs  <= map_valid & map_sram_cs;
            rd_valid <= sram_rd;
            // Idle and unselected accesses already arrive as all ones
            rom_addr <= map_addr;
        end
    end

    // The mapper never selects ROM and SRAM for the same access
    a_map_cs_onehot: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        map_valid |-> !(map_rom_cs && map_sram_cs));

endmodule

// ==== src/mapper_ascii8.sv ====
`include "msx_cart_config.svh"

module mapper_ascii8 (
    input  logic                     cpu_bus,
    input  logic                     arst_n,
    input  logic                     dec_valid,
    input  logic                     dec_rd,
    input  logic                     dec_wr,
    input  msx_cart_pkg::cpu_addr_t  dec_addr,
    input  msx_cart_pkg::cpu_data_t  dec_data,
    input  msx_cart_pkg::ctx_id_t    dec_ctx,
    input  logic                     dec_cs,
    input  logic                     dec_koei,
    input  logic                     dec_wizardy,
    input  msx_cart_pkg::rom_size_t  dec_rom_size,
    input  msx_cart_pkg::sram_size_t dec_sram_size,
    output logic                     map_valid,
    output logic                     map_rom_cs,
    output logic                     map_sram_cs,
    output logic                     map_sram_wr,
    output msx_cart_pkg::mem_addr_t  map_addr,
    output msx_cart_pkg::cpu_data_t  map_data
);
    import msx_cart_pkg::*;

    // Per-context mapper state
    bank_t      bank_q      [`MSX_CART_CONTEXTS][4];
    bank_t      sram_bank_q [`MSX_CART_CONTEXTS][4];
    logic [7:0] sram_en_q   [`MSX_CART_CONTEXTS];

    logic       sram_exists;
    bank_t      sram_mask;
    logic [7:0] sram_en_bit;
    logic [7:0] page_set;
    logic [1:0] region;
    logic [7:0] region_bit;
    logic       reg_wr;
    logic       sram_sel_wr;
    logic [1:0] slot;
    logic       page_sram;
    mem_addr_t  rom_addr_c;
    mem_addr_t  sram_addr_c;
    logic       rom_in_range;
    logic       rom_cs_c;
    logic       sram_cs_c;

    assign sram_exists = (dec_sram_size != '0);
    assign sram_mask   = (dec_sram_size[10:3] != '0) ? (dec_sram_size[10:3] - 8'd1) : 8'd0;

    // WIZARDY keeps its enable in bit 7, the others just above the ROM pages
    assign sram_en_bit = dec_wizardy ? 8'h80 : dec_rom_size[20:13];
    assign page_set    = dec_koei ? 8'h34 : 8'h30;

    // Register window 6000h..7FFFh, four 2 KB regions
    assign region      = dec_addr[12:11];
    assign region_bit  = 8'h04 << region;
    assign reg_wr      = dec_valid & dec_cs & dec_wr & (dec_addr[15:13] == 3'b011);
    assign sram_sel_wr = ((dec_data & sram_en_bit) != 8'h00) & sram_exists;

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            bank_q      <= '{default: '0};
            sram_bank_q <= '{default: '0};
            sram_en_q   <= '{default: '0};
        end else if (reg_wr) begin
            if (sram_sel_wr) begin
                sram_en_q[dec_ctx]           <= sram_en_q[dec_ctx] | (region_bit & page_set);
                sram_bank_q[dec_ctx][region] <= dec_data & sram_mask;
            end else begin
                sram_en_q[dec_ctx]      <= sram_en_q[dec_ctx] & ~region_bit;
                bank_q[dec_ctx][region] <= dec_data;
            end
        end
    end

    // Bank slot by address bits 15 and 13, page enable by the 8 KB page
    assign slot      = {dec_addr[15], dec_addr[13]};
    assign page_sram = sram_en_q[dec_ctx][dec_addr[15:13]];

    assign rom_addr_c   = {6'b0, bank_q[dec_ctx][slot], dec_addr[12:0]};
    assign sram_addr_c  = {6'b0, sram_bank_q[dec_ctx][slot], dec_addr[12:0]};
    assign rom_in_range = (rom_addr_c < {6'b0, dec_rom_size});

    assign sram_cs_c = dec_valid & dec_cs & page_sram & (dec_rd | dec_wr);
    assign rom_cs_c  = dec_valid & dec_cs & dec_rd & ~page_sram & rom_in_range;

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            map_valid   <= 1'b0;
            map_rom_cs  <= 1'b0;
            map_sram_cs <= 1'b0;
            map_sram_wr <= 1'b0;
        end else begin
            map_valid   <= dec_valid;
            map_rom_cs  <= rom_cs_c;
            map_sram_cs <= sram_cs_c;
            map_sram_wr <= sram_cs_c & dec_wr;
        end
    end

    // Unselected accesses carry an all-ones address
    always_ff @(posedge cpu_bus) begin
        if (sram_cs_c) begin
            map_addr <= sram_addr_c;
        end else if (rom_cs_c) begin
            map_addr <= rom_addr_c;
        end else begin
            map_addr <= '1;
        end
        map_data <= dec_data;
    end

    // A decoded request is a read or a write, never both
    a_dec_rd_wr_onehot: assert property (@(posedge cpu_bus) disable iff (!arst_n)
        dec_valid |-> !(dec_rd && dec_wr));

endmodule

// ==== src/msx_cart_pkg.sv ====
package msx_cart_pkg;

    // CPU side of the slot
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // One 8 KB page number
    typedef logic [7:0]  bank_t;

    // Physical address into the cartridge ROM or SRAM space
    typedef logic [26:0] mem_addr_t;

    // Cartridge context selector
    typedef logic [0:0]  ctx_id_t;

    // ROM size in bytes, up to 2 MB
    typedef logic [20:0] rom_size_t;

    // SRAM size, bits 10:3 give the page count
    typedef logic [10:0] sram_size_t;

    // Mapper families handled by the slot
    typedef enum logic [1:0] {
        MAPPER_NONE    = 2'd0,
        MAPPER_ASCII8  = 2'd1,
        MAPPER_KOEI    = 2'd2,
        MAPPER_WIZARDY = 2'd3
    } mapper_type_t;

endpackage

// ==== src/msx_cart_top.sv ====
module msx_cart_top (
    input  logic                       cpu_bus,
    input  logic                       arst_n,
    input  logic                       req,
    input  logic                       rd,
    input  logic                       wr,
    input  logic                       mreq,
    input  msx_cart_pkg::cpu_addr_t    addr,
    input  msx_cart_pkg::cpu_data_t    wr_data,
    input  msx_cart_pkg::ctx_id_t      ctx,
    input  msx_cart_pkg::mapper_type_t typ,
    input  msx_cart_pkg::rom_size_t    rom_size,
    input  msx_cart_pkg::sram_size_t   sram_size,
    output logic                       rom_rd,
    output msx_cart_pkg::mem_addr_t    rom_addr,
    output msx_cart_pkg::cpu_data_t    rd_data,
    output logic                       rd_valid,
    output logic                       sram_cs
);
    import msx_cart_pkg::*;

    // Decode to mapper
    logic       dec_valid;
    logic       dec_rd;
    logic       dec_wr;
    cpu_addr_t  dec_addr;
    cpu_data_t  dec_data;
    ctx_id_t    dec_ctx;
    logic       dec_cs;
    logic       dec_koei;
    logic       dec_wizardy;
    rom_size_t  dec_rom_size;
    sram_size_t dec_sram_size;

    // Mapper to memory port
    logic       map_valid;
    logic       map_rom_cs;
    logic       map_sram_cs;
    logic       map_sram_wr;
    mem_addr_t  map_addr;
    cpu_data_t  map_data;

    cart_bus_decode i_cart_bus_decode (
        .cpu_bus       (cpu_bus),
        .arst_n        (arst_n),
        .req           (req),
        .rd            (rd),
        .wr            (wr),
        .mreq          (mreq),
        .addr          (addr),
        .wr_data       (wr_data),
        .ctx           (ctx),
        .typ           (typ),
        .rom_size      (rom_size),
        .sram_size     (sram_size),
        .dec_valid     (dec_valid),
        .dec_rd        (dec_rd),
        .dec_wr        (dec_wr),
        .dec_addr      (dec_addr),
        .dec_data      (dec_data),
        .dec_ctx       (dec_ctx),
        .dec_cs        (dec_cs),
        .dec_koei      (dec_koei),
        .dec_wizardy   (dec_wizardy),
        .dec_rom_size  (dec_rom_size),
        .dec_sram_size (dec_sram_size)
    );

    mapper_ascii8 i_mapper_ascii8 (
        .cpu_bus       (cpu_bus),
        .arst_n        (arst_n),
        .dec_valid     (dec_valid),
        .dec_rd        (dec_rd),
        .dec_wr        (dec_wr),
        .dec_addr      (dec_addr),
        .dec_data      (dec_data),
        .dec_ctx       (dec_ctx),
        .dec_cs        (dec_cs),
        .dec_koei      (dec_koei),
        .dec_wizardy   (dec_wizardy),
        .dec_rom_size  (dec_rom_size),
        .dec_sram_size (dec_sram_size),
        .map_valid     (map_valid),
        .map_rom_cs    (map_rom_cs),
        .map_sram_cs   (map_sram_cs),
        .map_sram_wr   (map_sram_wr),
        .map_addr      (map_addr),
        .map_data      (map_data)
    );

    cart_mem_port i_cart_mem_port (
        .cpu_bus     (cpu_bus),
        .arst_n      (arst_n),
        .map_valid   (map_valid),
        .map_rom_cs  (map_rom_cs),
        .map_sram_cs (map_sram_cs),
        .map_sram_wr (map_sram_wr),
        .map_addr    (map_addr),
        .map_data    (map_data),
        .rom_rd      (rom_rd),
        .rom_addr    (rom_addr),
        .sram_cs     (sram_cs),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid)
    );

endmodule

// ==== testbench/msx_cart_trace.txt ====
# op ctx typ rom_size sram_size mreq addr data : expected rom_rd rom_addr sram_cs rd_data
# All hex; op 0 idle, 1 read, 2 write; typ 0 none, 1 ascii8, 2 koei, 3 wizardy
1 0 1 20000 000 1 4000 00 1 0000000 0 00
1 0 1 20000 000 1 a000 00 1 0000000 0 00
2 0 1 20000 000 1 6000 03 0 7ffffff 0 00
2 0 1 20000 000 1 6800 07 0 7ffffff 0 00
2 0 1 20000 000 1 7000 0a 0 7ffffff 0 00
2 0 1 20000 000 1 7800 0f 0 7ffffff 0 00
1 0 1 20000 000 1 4123 00 1 0006123 0 00
1 0 1 20000 000 1 6456 00 1 000e456 0 00
1 0 1 20000 000 1 8abc 00 1 0014abc 0 00
1 0 1 20000 000 1 bfff 00 1 001ffff 0 00
0 0 1 20000 000 1 0000 00 0 7ffffff 0 00
1 0 1 20000 000 1 0000 00 0 7ffffff 0 00
1 0 1 20000 000 1 3fff 00 0 7ffffff 0 00
1 0 1 20000 000 1 c000 00 0 7ffffff 0 00
1 0 1 20000 000 1 ffff 00 0 7ffffff 0 00
1 0 1 20000 000 0 4123 00 0 7ffffff 0 00
1 0 0 20000 000 1 4123 00 0 7ffffff 0 00
2 0 0 20000 000 1 6000 05 0 7ffffff 0 00
1 0 1 20000 000 1 4123 00 1 0006123 0 00
2 0 1 20000 008 1 7000 10 0 7ffffff 0 00
2 0 1 20000 008 1 8005 5a 0 0000005 1 00
1 0 1 20000 008 1 8005 00 0 0000005 1 5a
2 0 1 20000 008 1 9fff c3 0 0001fff 1 00
1 0 1 20000 008 1 9fff 00 0 0001fff 1 c3
1 0 1 20000 008 1 a010 00 1 001e010 0 00
2 0 1 20000 008 1 7000 05 0 7ffffff 0 00
1 0 1 20000 008 1 8005 00 1 000a005 0 00
2 0 2 20000 008 1 6000 10 0 7ffffff 0 00
2 0 2 20000 008 1 4010 77 0 0000010 1 00
1 0 2 20000 008 1 4010 00 0 0000010 1 77
2 0 2 20000 008 1 6000 03 0 7ffffff 0 00
1 0 2 20000 008 1 4010 00 1 0006010 0 00
2 0 1 20000 008 1 6000 10 0 7ffffff 0 00
1 0 1 20000 008 1 4010 00 1 0006010 0 00
2 0 3 20000 008 1 7800 10 0 7ffffff 0 00
1 0 3 20000 008 1 a100 00 0 7ffffff 0 00
2 0 3 20000 008 1 7800 80 0 7ffffff 0 00
2 0 3 20000 008 1 a100 3c 0 0000100 1 00
1 0 3 20000 008 1 a100 00 0 0000100 1 3c
2 0 3 20000 008 1 7800 0f 0 7ffffff 0 00
1 0 3 20000 008 1 a100 00 1 001e100 0 00
2 1 1 20000 000 1 6000 02 0 7ffffff 0 00
1 1 1 20000 000 1 4020 00 1 0004020 0 00
2 0 1 20000 000 1 6000 09 0 7ffffff 0 00
1 1 1 20000 000 1 4020 00 1 0004020 0 00
1 0 1 20000 000 1 4020 00 1 0012020 0 00
1 1 1 20000 000 1 8000 00 1 0000000 0 00
1 0 1 20000 000 1 8000 00 1 000a000 0 00

// ==== testbench/tb_msx_cart.sv ====
`include "msx_cart_config.svh"

module tb_msx_cart;
    import msx_cart_pkg::*;

    localparam int RD_TIMEOUT = 12;

    logic         cpu_bus;
    logic         arst_n    = 1'b0;
    logic         req       = 1'b0;
    logic         rd        = 1'b0;
    logic         wr        = 1'b0;
    logic         mreq      = 1'b0;
    cpu_addr_t    addr      = '0;
    cpu_data_t    wr_data   = '0;
    ctx_id_t      ctx       = '0;
    mapper_type_t typ       = MAPPER_NONE;
    rom_size_t    rom_size  = '0;
    sram_size_t   sram_size = '0;
    logic         rom_rd;
    mem_addr_t    rom_addr;
    cpu_data_t    rd_data;
    logic         rd_valid;
    logic         sram_cs;

    int checks       = 0;
    int value_errors = 0;
    int timeouts     = 0;
    int trace_errors = 0;
    // Current trace line, one entry per column
    int col [12];

    msx_cart_top i_msx_cart_top (.*);

    initial begin
        cpu_bus = 1'b0;
        forever #2 cpu_bus = ~cpu_bus;
    end

    task automatic check_mem_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s rom_addr %07h, expected %07h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input cpu_data_t got, input cpu_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s rd_data %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            value_errors++;
            $display("[FAIL] %0t: %s read latency %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Drive one trace line on the falling edge and follow it to the memory port
    task automatic run_access(input int line_no);
        string where;
        logic  expect_rd;
        logic  got_valid;
        int    cycles;
        int    limit;

        where     = $sformatf("trace line %0d", line_no);
        expect_rd = (col[0] == 1) && (col[10] != 0);
        limit     = expect_rd ? RD_TIMEOUT : `MSX_CART_RD_LATENCY;
        req       = (col[0] != 0);
        rd        = (col[0] == 1);
        wr        = (col[0] == 2);
        ctx       = col[1][0];
        typ       = mapper_type_t'(col[2][1:0]);
        rom_size  = col[3][20:0];
        sram_size = col[4][10:0];
        mreq      = col[5][0];
        addr      = col[6][15:0];
        wr_data   = col[7][7:0];
        cycles    = 0;
        got_valid = 1'b0;
        // Request edge first, outputs settle after the third edge
        while (cycles < limit && !got_valid) begin
            @(posedge cpu_bus);
            cycles++;
            @(negedge cpu_bus);
            req       = 1'b0;
            rd        = 1'b0;
            wr        = 1'b0;
            got_valid = rd_valid;
        end
        if (expect_rd && !got_valid) begin
            timeouts++;
            $display("Timeout: rd_valid never rose for the SRAM read on %s", where);
        end else begin
            if (expect_rd) begin
                check_latency(cycles, `MSX_CART_RD_LATENCY, where);
                check_data(rd_data, col[11][7:0], where);
            end else begin
                check_flag(got_valid, 1'b0, {where, " rd_valid"});
            end
            check_flag(rom_rd, col[8][0], {where, " rom_rd"});
            check_mem_addr(rom_addr, col[9][26:0], where);
            check_flag(sram_cs, col[10][0], {where, " sram_cs"});
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    line_no;
        int    accesses;
        string line;

        line_no  = 0;
        accesses = 0;
        repeat (16) @(posedge cpu_bus);
        @(negedge cpu_bus);
        arst_n = 1'b1;
        check_flag(rom_rd, 1'b0, "reset rom_rd");
        check_flag(rd_valid, 1'b0, "reset rd_valid");
        check_flag(sram_cs, 1'b0, "reset sram_cs");

        fd = $fopen("testbench/msx_cart_trace.txt", "r");
        if (fd == 0) begin
            trace_errors++;
            $display("Could not open testbench/msx_cart_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                                col[9], col[10], col[11]);
                    if (n == 12) begin
                        accesses++;
                        run_access(line_no);
                    end else begin
                        trace_errors++;
                        $display("Trace line %0d holds %0d fields instead of 12", line_no, n);
                    end
                end
            end
            $fclose(fd);
        end
        if (accesses == 0) begin
            trace_errors++;
            $display("No accesses were read from the trace");
        end

        $display("Accesses %0d, checks %0d, value errors %0d, timeouts %0d, trace errors %0d",
                 accesses, checks, value_errors, timeouts, trace_errors);
        if (value_errors == 0 && timeouts == 0 && trace_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
